// ==== rtl/binRam.sv ====
`timescale 1ns/1ps

module binRam #(
    parameter int binBits = 4
) (
    input  logic                clk,
    input  logic                we,
    input  logic [binBits-1:0]  waddr,
    input  histPkg::binCount_t  wdata,
    input  logic [binBits-1:0]  raddr,
    output histPkg::binCount_t  rdata
);
    import histPkg::*;

    localparam int binNum = 2 ** binBits;

    binCount_t mem [binNum];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, one cycle latency
    // same-address write in the same cycle returns the old value
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/histEngine.sv ====
`timescale 1ns/1ps

module histEngine #(
    parameter int binBits = 4
) (
    input  logic                clk,
    input  logic                res,
    input  logic                engHit,
    input  logic [binBits-1:0]  engBin,
    input  logic                engClear,
    input  logic                engFrameEnd,
    output logic                peakReady,
    output logic [binBits-1:0]  peakBin,
    output histPkg::binCount_t  peakCount,
    output logic                busy
);
    import histPkg::*;

    localparam int binNum = 2 ** binBits;

    engineState_t state;
    logic [binBits:0] cnt; // clear address, drain count or scan address

    // read stage
    logic rdHit;
    logic [binBits-1:0] rdBin;

    // write stage
    logic wrHit;
    logic [binBits-1:0] wrBin;
    logic fwdSel;
    binCount_t fwdVal;
    binCount_t baseVal;
    binCount_t incVal;

    // ram ports
    logic we;
    logic [binBits-1:0] waddr;
    binCount_t wdata;
    logic [binBits-1:0] raddr;
    binCount_t rdata;
    logic [binBits-1:0] scanBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stIdle;
            cnt       <= '0;
            peakReady <= 1'b0;
        end else if (engClear) begin
            state     <= stClear; // restart from any phase
            cnt       <= '0;
            peakReady <= 1'b0;
        end else begin
            case (state)
                stClear: begin
                    if (cnt == binNum - 1) begin
                        state <= stAccum;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                stAccum: begin
                    if (engFrameEnd) begin
                        state <= stDrain;
                        cnt   <= '0;
                    end
                end
                stDrain: begin
                    if (cnt == 1) begin // two cycles
                        state <= stScan;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                stScan: begin
                    if (cnt == binNum) begin
                        state     <= stIdle;
                        peakReady <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: ; // idle until the next clear
            endcase
        end
    end

    assign busy = (state == stClear) || (state == stDrain) || (state == stScan);

    // a clear kills whatever is in flight
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdHit  <= 1'b0;
            wrHit  <= 1'b0;
            fwdSel <= 1'b0;
        end else begin
            rdHit  <= engHit && (state == stAccum) && !engClear;
            wrHit  <= rdHit && !engClear;
            fwdSel <= rdHit && wrHit && (rdBin == wrBin) && !engClear; // back-to-back same bin
        end
    end

    always_ff @(posedge clk) begin
        rdBin  <= engBin;
        wrBin  <= rdBin;
        fwdVal <= incVal;
    end

    // ram output is stale when the previous write hit the same bin
    assign baseVal = fwdSel ? fwdVal : rdata;
    assign incVal  = (baseVal == '1) ? baseVal : baseVal + 1'b1;

    assign we      = (state == stClear) || wrHit;
    assign waddr   = (state == stClear) ? cnt[binBits-1:0] : wrBin;
    assign wdata   = (state == stClear) ? '0 : incVal;
    assign raddr   = (state == stScan) ? cnt[binBits-1:0] : rdBin;
    assign scanBin = binBits'(cnt - 1'b1); // bin whose data is on rdata now

    // running maximum, strictly larger wins so ties stay on the lowest bin
    always_ff @(posedge clk) begin
        if (state == stDrain) begin
            peakCount <= '0;
            peakBin   <= '0;
        end else if (state == stScan && cnt != 0 && rdata > peakCount) begin
            peakCount <= rdata;
            peakBin   <= scanBin;
        end
    end

    binRam #(
        .binBits(binBits)
    ) ram (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

    // the pipeline only ever fills from stAccum
    noIdleWrite: assert property (@(posedge clk) disable iff (!res)
        !(we && state == stIdle))
        else $error("bin write while idle");

    // collector and router expect clear only outside the readout
    noClearInScan: assert property (@(posedge clk) disable iff (!res)
        engClear |-> !(state inside {stDrain, stScan}))
        else $error("clear during drain or scan");

endmodule

// ==== rtl/histPkg.sv ====
package histPkg;

    // hit arrival time
    localparam int stampW = 10;
    typedef logic [stampW-1:0] stamp_t;

    // one histogram bin, all ones is the saturation level
    localparam int countW = 8;
    typedef logic [countW-1:0] binCount_t;

    localparam int dropW = 16; // dropped-hit counter
    typedef logic [dropW-1:0] dropCount_t;

    // per-pixel engine phases
    typedef enum logic [2:0] {
        stIdle,  // after reset or after a finished scan
        stClear, // zeroing one bin per cycle
        stAccum, // taking hits
        stDrain, // read-modify-write pipeline empties
        stScan   // peak search over all bins
    } engineState_t;

endpackage

// ==== rtl/histTop.sv ====
`timescale 1ns/1ps

module histTop #(
    parameter int pixelNum = 4, // 2 to 16
    parameter int binBits  = 4  // 2 to stampW
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 clear,
    input  logic                 hit,
    input  logic [3:0]           hitPixel,
    input  histPkg::stamp_t      hitStamp,
    input  logic                 frameEnd,
    output logic                 busy,
    output logic                 peakValid,
    output logic [3:0]           peakPixel,
    output logic [binBits-1:0]   peakBin,
    output histPkg::binCount_t   peakCount,
    output logic                 frameDone,
    output histPkg::dropCount_t  dropCount
);
    import histPkg::*;

    logic [pixelNum-1:0] engHit;
    logic [binBits-1:0] engBin;
    logic engClear;
    logic engFrameEnd;
    logic [pixelNum-1:0] peakReady;
    logic [pixelNum*binBits-1:0] peakBinAll;
    logic [pixelNum*countW-1:0] peakCountAll;
    logic [pixelNum-1:0] engBusy;

    assign busy = |engBusy;

    stampRouter #(
        .pixelNum(pixelNum),
        .binBits (binBits)
    ) router (
        .clk         (clk),
        .res         (res),
        .clear       (clear),
        .hit         (hit),
        .hitPixel    (hitPixel),
        .hitStamp    (hitStamp),
        .frameEnd    (frameEnd),
        .engHit      (engHit),
        .engBin      (engBin),
        .engClear    (engClear),
        .engFrameEnd (engFrameEnd),
        .dropCount   (dropCount)
    );

    // one histogram engine per pixel
    for (genvar p = 0; p < pixelNum; p++) begin : gEngine
        histEngine #(
            .binBits(binBits)
        ) engine (
            .clk         (clk),
            .res         (res),
            .engHit      (engHit[p]),
            .engBin      (engBin),
            .engClear    (engClear),
            .engFrameEnd (engFrameEnd),
            .peakReady   (peakReady[p]),
            .peakBin     (peakBinAll[p*binBits +: binBits]),
            .peakCount   (peakCountAll[p*countW +: countW]),
            .busy        (engBusy[p])
        );
    end

    peakCollector #(
        .pixelNum(pixelNum),
        .binBits (binBits)
    ) collector (
        .clk          (clk),
        .res          (res),
        .engFrameEnd  (engFrameEnd),
        .peakReady    (peakReady),
        .peakBinAll   (peakBinAll),
        .peakCountAll (peakCountAll),
        .peakValid    (peakValid),
        .peakPixel    (peakPixel),
        .peakBin      (peakBin),
        .peakCount    (peakCount),
        .frameDone    (frameDone)
    );

endmodule

// ==== rtl/peakCollector.sv ====
`timescale 1ns/1ps

module peakCollector #(
    parameter int pixelNum = 4,
    parameter int binBits  = 4
) (
    input  logic                                   clk,
    input  logic                                   res,
    input  logic                                   engFrameEnd,
    input  logic [pixelNum-1:0]                    peakReady,
    input  logic [pixelNum*binBits-1:0]            peakBinAll,
    input  logic [pixelNum*histPkg::countW-1:0]    peakCountAll,
    output logic                                   peakValid,
    output logic [3:0]                             peakPixel,
    output logic [binBits-1:0]                     peakBin,
    output histPkg::binCount_t                     peakCount,
    output logic                                   frameDone
);
    import histPkg::*;

    typedef enum logic [1:0] {
        colIdle,
        colArmed,
        colStream
    } colState_t;

    colState_t state;
    logic [4:0] pixCnt; // reaches pixelNum, up to 16
    logic [3:0] pixSel;
    logic allReady;
    logic loadRes;

    assign allReady = &peakReady;

    // pixel 0 goes out straight from the armed state
    assign loadRes = (state == colArmed && allReady) ||
                     (state == colStream && pixCnt < pixelNum);
    assign pixSel  = (state == colStream && pixCnt < pixelNum) ? pixCnt[3:0] : 4'd0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= colIdle;
            pixCnt    <= '0;
            peakValid <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            peakValid <= loadRes;
            frameDone <= 1'b0;
            case (state)
                colIdle: begin
                    if (engFrameEnd) state <= colArmed;
                end
                colArmed: begin
                    if (allReady) begin
                        state  <= colStream;
                        pixCnt <= 5'd1;
                    end
                end
                colStream: begin
                    if (pixCnt == pixelNum) begin
                        frameDone <= 1'b1; // right after the last result
                        state     <= colIdle;
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                    end
                end
                default: state <= colIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadRes) begin
            peakPixel <= pixSel;
            peakBin   <= peakBinAll[pixSel*binBits +: binBits];
            peakCount <= peakCountAll[pixSel*countW +: countW];
        end
    end

    resultThenDone: assert property (@(posedge clk) disable iff (!res)
        !(peakValid && frameDone))
        else $error("peakValid and frameDone overlap");

endmodule

// ==== rtl/stampRouter.sv ====
`timescale 1ns/1ps

module stampRouter #(
    parameter int pixelNum = 4,
    parameter int binBits  = 4
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 clear,
    input  logic                 hit,
    input  logic [3:0]           hitPixel,
    input  histPkg::stamp_t      hitStamp,
    input  logic                 frameEnd,
    output logic [pixelNum-1:0]  engHit,
    output logic [binBits-1:0]   engBin,
    output logic                 engClear,
    output logic                 engFrameEnd,
    output histPkg::dropCount_t  dropCount
);
    import histPkg::*;

    logic inRange;

    assign inRange = hitPixel < pixelNum;

    // strobes and pulses, one cycle behind the inputs
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            engHit      <= '0;
            engClear    <= 1'b0;
            engFrameEnd <= 1'b0;
        end else begin
            for (int p = 0; p < pixelNum; p++) begin
                engHit[p] <= hit && (hitPixel == p); // out-of-range index selects nobody
            end
            engClear    <= clear;
            engFrameEnd <= frameEnd;
        end
    end

    always_ff @(posedge clk) begin
        engBin <= hitStamp[stampW-1 -: binBits]; // bin = top bits of the stamp
    end

    // tally of hits for pixels that do not exist
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dropCount <= '0;
        end else if (clear) begin
            dropCount <= '0;
        end else if (hit && !inRange && dropCount != '1) begin
            dropCount <= dropCount + 1'b1; // holds at max
        end
    end

    // at most one engine takes a given hit
    engHitOneHot: assert property (@(posedge clk) disable iff (!res) $onehot0(engHit))
        else $error("engHit is not one-hot");

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module histTb -o histTb &&
./obj_dir/histTb || exit 1

// ==== sim/histTb.sv ====
`timescale 1ns/1ps

module histTb;
    import histPkg::*;

    localparam int pixelNum = 4;
    localparam int binBits  = 4;
    localparam int binNum   = 2 ** binBits;
    localparam int readyLat = binNum + 4; // edges from taking frameEnd to peakReady
    localparam int countMax = 2 ** countW - 1;
    localparam int dropMax  = 2 ** dropW - 1;

    // table row kinds
    localparam int kClear = 0;
    localparam int kHit   = 1;
    localparam int kFrame = 2;
    localparam int kRand  = 3;

    logic clk;
    logic res;
    logic clear;
    logic hit;
    logic [3:0] hitPixel;
    stamp_t hitStamp;
    logic frameEnd;
    logic busy;
    logic peakValid;
    logic [3:0] peakPixel;
    logic [binBits-1:0] peakBin;
    binCount_t peakCount;
    logic frameDone;
    dropCount_t dropCount;

    int kindQ[$];
    int pixQ[$];
    int stampQ[$];
    int repQ[$];

    int model [pixelNum][binNum]; // expected histograms
    int dropTally;
    logic [31:0] lfsr;
    int cycleCount;
    int cycleLimit;

    histTop #(
        .pixelNum(pixelNum),
        .binBits (binBits)
    ) UUT (
        .clk       (clk),
        .res       (res),
        .clear     (clear),
        .hit       (hit),
        .hitPixel  (hitPixel),
        .hitStamp  (hitStamp),
        .frameEnd  (frameEnd),
        .busy      (busy),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .frameDone (frameDone),
        .dropCount (dropCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic stopOnError(input string msg);
        $display("%0t: %s", $time, msg);
        abortRun();
    endtask

    task automatic checkCount(input string name, input binCount_t exp, input binCount_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkBin(input string name, input logic [binBits-1:0] exp,
                            input logic [binBits-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkPixel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkDrop(input string name, input dropCount_t exp, input dropCount_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abortRun();
        end
    endtask

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsrStep(lfsr);
        end
        return v;
    endfunction

    function automatic void modelHit(input int pix, input int stamp);
        int bin;
        bin = (stamp >> (stampW - binBits)) % binNum; // top bits of the stamp
        if (pix >= pixelNum) begin
            if (dropTally < dropMax) dropTally++;
        end else if (model[pix][bin] < countMax) begin
            model[pix][bin]++;
        end
    endfunction

    // first strictly larger count wins
    function automatic void peakOf(input int pix, output int bin, output int cnt);
        bin = 0;
        cnt = 0;
        for (int b = 0; b < binNum; b++) begin
            if (model[pix][b] > cnt) begin
                cnt = model[pix][b];
                bin = b;
            end
        end
    endfunction

    task automatic addRow(input int kind, input int pix, input int stamp, input int rep);
        kindQ.push_back(kind);
        pixQ.push_back(pix);
        stampQ.push_back(stamp);
        repQ.push_back(rep);
    endtask

    task automatic buildTable();
        addRow(kClear, 0, 0, 1); // empty frame
        addRow(kFrame, 0, 0, 1);
        addRow(kClear, 0, 0, 1); // directed hits
        addRow(kHit, 0, 10'h0C5, 5);
        addRow(kHit, 0, 10'h1E0, 3);
        addRow(kHit, 1, 10'h080, 1); // alternating bins 2 and 9
        addRow(kHit, 1, 10'h240, 1);
        addRow(kHit, 1, 10'h080, 1);
        addRow(kHit, 1, 10'h240, 1);
        addRow(kHit, 1, 10'h080, 1);
        addRow(kHit, 2, 10'h140, 2);
        addRow(kHit, 3, 10'h140, 1);
        addRow(kHit, 2, 10'h140, 1);
        addRow(kHit, 3, 10'h300, 2); // tie between bins 12 and 4
        addRow(kHit, 3, 10'h100, 2);
        addRow(kHit, 9, 10'h3FF, 3);
        addRow(kFrame, 0, 0, 1);
        addRow(kClear, 0, 0, 1); // random frame
        addRow(kRand, 0, 0, 200);
        addRow(kFrame, 0, 0, 1);
        addRow(kClear, 0, 0, 1); // saturation
        addRow(kHit, 15, 10'h011, 2);
        addRow(kHit, 2, 10'h2AB, 300);
        addRow(kHit, 1, 10'h3C0, 1);
        addRow(kFrame, 0, 0, 1);
    endtask

    function automatic int cycleBudget();
        int total;
        total = 4; // reset
        foreach (kindQ[i]) begin
            case (kindQ[i])
                kClear:  total += binNum + 6;
                kFrame:  total += readyLat + pixelNum + 6;
                default: total += repQ[i];
            endcase
        end
        return total + 100;
    endfunction

    task automatic driveHit(input int pix, input int stamp);
        @(posedge clk);
        hit      <= 1'b1;
        hitPixel <= 4'(pix);
        hitStamp <= stamp_t'(stamp);
        modelHit(pix, stamp);
    endtask

    task automatic randomBurst(input int n);
        int pix;
        int stamp;
        for (int i = 0; i < n; i++) begin
            pix   = takeBits(4);
            stamp = takeBits(stampW);
            driveHit(pix, stamp);
        end
    endtask

    task automatic startClear();
        int waitCnt;
        @(posedge clk);
        hit   <= 1'b0;
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (busy !== 1'b1) begin
            waitCnt++;
            if (waitCnt > 4) stopOnError("busy did not rise after clear");
            @(negedge clk);
        end
        waitCnt = 0;
        while (busy !== 1'b0) begin
            waitCnt++;
            if (waitCnt > binNum + 2) stopOnError("clear phase did not end in time");
            @(negedge clk);
        end
        foreach (model[p, b]) model[p][b] = 0;
        dropTally = 0;
        checkDrop("dropCount", '0, dropCount);
    endtask

    task automatic endFrame();
        int expBin;
        int expCnt;
        @(posedge clk);
        hit      <= 1'b0;
        frameEnd <= 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
        repeat (readyLat) begin
            @(negedge clk);
            if (UUT.peakReady !== '0) stopOnError("peakReady rose before the scan could end");
        end
        @(negedge clk);
        if (UUT.peakReady !== '1) stopOnError("peakReady not high at the expected latency");
        for (int p = 0; p < pixelNum; p++) begin
            @(negedge clk);
            if (peakValid !== 1'b1) stopOnError($sformatf("no result for pixel %0d", p));
            peakOf(p, expBin, expCnt);
            checkPixel("peakPixel", 4'(p), peakPixel);
            checkBin("peakBin", binBits'(expBin), peakBin);
            checkCount("peakCount", binCount_t'(expCnt), peakCount);
            checkFlag("frameDone", 1'b0, frameDone);
        end
        @(negedge clk);
        checkFlag("peakValid", 1'b0, peakValid);
        checkFlag("frameDone", 1'b1, frameDone);
        checkDrop("dropCount", dropCount_t'(dropTally), dropCount);
        @(negedge clk);
        checkFlag("frameDone", 1'b0, frameDone);
        checkFlag("busy", 1'b0, busy);
    endtask

    // watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("%0t: run exceeded %0d cycles", $time, cycleLimit);
            abortRun();
        end
    end

    initial begin
        res        = 1'b0;
        clear      = 1'b0;
        hit        = 1'b0;
        hitPixel   = '0;
        hitStamp   = '0;
        frameEnd   = 1'b0;
        lfsr       = 32'haedb8544;
        dropTally  = 0;
        cycleCount = 0;
        buildTable();
        cycleLimit = cycleBudget();
        repeat (2) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        checkFlag("busy", 1'b0, busy);
        checkFlag("peakValid", 1'b0, peakValid);
        checkFlag("frameDone", 1'b0, frameDone);
        checkDrop("dropCount", '0, dropCount);
        foreach (kindQ[i]) begin
            case (kindQ[i])
                kClear:  startClear();
                kHit:    repeat (repQ[i]) driveHit(pixQ[i], stampQ[i]);
                kRand:   randomBurst(repQ[i]);
                kFrame:  endFrame();
                default: stopOnError("unknown row kind in the stimulus table");
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/histPkg.sv
rtl/stampRouter.sv
rtl/binRam.sv
rtl/histEngine.sv
rtl/peakCollector.sv
rtl/histTop.sv
sim/histTb.sv
